// ==== source/pio_isa_pkg.sv ====
package pio_isa_pkg;

  typedef logic [31:0] word_t;  // Scratch, shift registers, pins and FIFO data
  typedef logic [15:0] instr_t;
  typedef logic [4:0]  addr_t;  // Program memory holds 32 instructions
  typedef logic [4:0]  delay_t;
  typedef logic [2:0]  op1_t;
  typedef logic [4:0]  op2_t;

  typedef enum logic [2:0] {
    OP_JMP       = 3'd0,
    OP_WAIT      = 3'd1,
    OP_IN        = 3'd2,
    OP_OUT       = 3'd3,
    OP_PUSH_PULL = 3'd4,
    OP_MOV       = 3'd5,
    OP_IRQ       = 3'd6,  // Not implemented, runs as a no-op
    OP_SET       = 3'd7
  } opcode_e;

  typedef enum logic [1:0] {
    BIT_NONE    = 2'd0,
    BIT_INVERT  = 2'd1,
    BIT_REVERSE = 2'd2
  } bit_op_e;

  // Low bit of each instruction field
  localparam int OPCODE_LSB = 13;
  localparam int DELAY_LSB  = 8;
  localparam int OP1_LSB    = 5;
  localparam int OP2_LSB    = 0;
  localparam int MOV_OP_LSB = 3;  // Bit operation sits in op2[4:3]

  localparam op1_t COND_ALWAYS = 3'd0;
  localparam op1_t COND_X_ZERO = 3'd1;
  localparam op1_t COND_X_DEC  = 3'd2;  // X nonzero, then X--
  localparam op1_t COND_Y_ZERO = 3'd3;
  localparam op1_t COND_Y_DEC  = 3'd4;
  localparam op1_t COND_X_NE_Y = 3'd5;

  localparam op1_t SRC_PINS = 3'd0;
  localparam op1_t SRC_X    = 3'd1;
  localparam op1_t SRC_Y    = 3'd2;
  localparam op1_t SRC_NULL = 3'd3;
  localparam op1_t SRC_ISR  = 3'd6;
  localparam op1_t SRC_OSR  = 3'd7;

  localparam op1_t DST_PINS = 3'd0;
  localparam op1_t DST_X    = 3'd1;
  localparam op1_t DST_Y    = 3'd2;
  localparam op1_t DST_NULL = 3'd3;

  localparam logic [1:0] WAIT_SRC_GPIO = 2'd0;
  localparam int WAIT_POL_BIT = 2;  // Level to wait for
  localparam int PULL_BIT     = 2;

endpackage

// ==== source/pio_cfg_pkg.sv ====
package pio_cfg_pkg;

  localparam int DIV_W       = 16;
  localparam int PIN_INDEX_W = 5;
  localparam int PIN_COUNT_W = 3;
  localparam int MAX_PINS    = 5;  // Widest SET or OUT pin group

  typedef logic [DIV_W-1:0]       clk_div_t;
  typedef logic [PIN_INDEX_W-1:0] pin_index_t;  // Base pin, wraps modulo 32
  typedef logic [PIN_COUNT_W-1:0] pin_count_t;

endpackage

// ==== source/clock_divider.sv ====
`timescale 1ns/10ps
module clock_divider (
  input  logic                  clk,
  input  logic                  reset,
  input  pio_cfg_pkg::clk_div_t div,
  output logic                  tick
);
  import pio_cfg_pkg::*;

  clk_div_t count;  // Cycles left until the next tick

  // Divide by 0 or 1 runs at full rate
  assign tick = (div <= clk_div_t'(1)) || (count <= clk_div_t'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= div;
    end else if (tick) begin
      count <= div;  // Reload on wrap
    end else begin
      count <= count - clk_div_t'(1);
    end
  end

  a_tick_spacing: assert property (@(posedge clk) disable iff (reset)
    (tick && div > clk_div_t'(1)) |=> (!tick || div <= clk_div_t'(1)))
    else $error("tick high on back-to-back cycles with div above 1");

endmodule

// ==== source/sm_control.sv ====
`timescale 1ns/10ps
module sm_control (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    en,
  input  logic                    tick,
  input  logic                    din_valid,
  input  logic                    dout_ready,
  input  pio_isa_pkg::instr_t     instr,
  input  pio_isa_pkg::word_t      x,
  input  pio_isa_pkg::word_t      y,
  input  pio_isa_pkg::word_t      isr,
  input  pio_isa_pkg::word_t      osr,
  input  pio_isa_pkg::word_t      din,
  input  pio_isa_pkg::word_t      input_pins,
  input  pio_isa_pkg::word_t      gpio_pins,
  input  pio_cfg_pkg::pin_index_t pins_in_base,
  output logic                    advance,
  output logic                    jump,
  output logic                    load_x,
  output logic                    load_y,
  output logic                    dec_x,
  output logic                    dec_y,
  output logic                    isr_shift,
  output logic                    isr_clear,
  output logic                    osr_shift,
  output logic                    osr_load,
  output logic                    set_pins,
  output logic                    out_pins,
  output logic                    din_ready,
  output logic                    dout_valid,
  output pio_isa_pkg::op2_t       shift_count,
  output pio_isa_pkg::word_t      new_val
);
  import pio_isa_pkg::*;

  opcode_e opcode;
  bit_op_e mov_op;
  op1_t    op1;
  op2_t    op2;
  op1_t    src_code;
  delay_t  delay;
  delay_t  delay_cnt;
  word_t   in_pins;
  word_t   src_val;
  logic    src_ok;
  logic    src_shifter;  // Source is ISR or OSR
  logic    enabled;
  logic    delaying;
  logic    active;
  logic    stall;

  function automatic word_t apply_bit_op(word_t value, bit_op_e op);
    word_t result;
    case (op)
      BIT_INVERT:  result = ~value;
      BIT_REVERSE: begin
        for (int i = 0; i < $bits(word_t); i++) begin
          result[i] = value[$bits(word_t) - 1 - i];
        end
      end
      default:     result = value;  // Code 3 acts as none
    endcase
    return result;
  endfunction

  assign opcode = opcode_e'(instr[OPCODE_LSB +: 3]);
  assign delay  = instr[DELAY_LSB +: $bits(delay_t)];
  assign op1    = instr[OP1_LSB +: $bits(op1_t)];
  assign op2    = instr[OP2_LSB +: $bits(op2_t)];
  assign mov_op = bit_op_e'(op2[MOV_OP_LSB +: 2]);

  assign enabled     = en && tick;
  assign delaying    = (delay_cnt != '0);
  assign active      = enabled && !delaying;
  assign advance     = active && !stall;
  assign shift_count = op2;  // 0 means a full word

  // Pin group starts at bit 0 after rotating by the IN base
  assign in_pins = word_t'({input_pins, input_pins} >> pins_in_base);

  // MOV takes its source from op2, IN from op1
  assign src_code = (opcode == OP_MOV) ? op2[2:0] : op1;

  always_comb begin
    src_ok      = 1'b1;
    src_shifter = 1'b0;
    case (src_code)
      SRC_PINS: src_val = in_pins;
      SRC_X:    src_val = x;
      SRC_Y:    src_val = y;
      SRC_NULL: src_val = '0;
      SRC_ISR: begin
        src_val     = isr;
        src_shifter = 1'b1;
      end
      SRC_OSR: begin
        src_val     = osr;
        src_shifter = 1'b1;
      end
      default: begin
        src_val = '0;
        src_ok  = 1'b0;
      end
    endcase
  end

  always_comb begin
    jump       = 1'b0;
    load_x     = 1'b0;
    load_y     = 1'b0;
    dec_x      = 1'b0;
    dec_y      = 1'b0;
    isr_shift  = 1'b0;
    isr_clear  = 1'b0;
    osr_shift  = 1'b0;
    osr_load   = 1'b0;
    set_pins   = 1'b0;
    out_pins   = 1'b0;
    din_ready  = 1'b0;
    dout_valid = 1'b0;
    stall      = 1'b0;
    new_val    = '0;
    if (active) begin
      case (opcode)
        OP_JMP: begin
          new_val = word_t'(op2);  // Jump target
          case (op1)
            COND_ALWAYS: jump = 1'b1;
            COND_X_ZERO: jump = (x == '0);
            COND_X_DEC: begin
              jump  = (x != '0);
              dec_x = 1'b1;  // Post-decrement in any case
            end
            COND_Y_ZERO: jump = (y == '0);
            COND_Y_DEC: begin
              jump  = (y != '0);
              dec_y = 1'b1;
            end
            COND_X_NE_Y: jump = (x != y);
            default:     jump = 1'b0;
          endcase
        end
        OP_WAIT: begin
          if (op1[1:0] == WAIT_SRC_GPIO) begin
            stall = (gpio_pins[op2] != op1[WAIT_POL_BIT]);
          end
        end
        OP_IN: begin
          isr_shift = src_ok && !src_shifter;
          new_val   = src_val;
        end
        OP_OUT: begin
          osr_shift = (op1 == DST_PINS) || (op1 == DST_X) ||
                      (op1 == DST_Y) || (op1 == DST_NULL);
          out_pins  = (op1 == DST_PINS);
          load_x    = (op1 == DST_X);
          load_y    = (op1 == DST_Y);
        end
        OP_PUSH_PULL: begin
          if (op1[PULL_BIT]) begin
            din_ready = 1'b1;
            stall     = !din_valid;  // Blocks on empty RX FIFO
            osr_load  = din_valid;
            new_val   = din;
          end else begin
            dout_valid = 1'b1;
            stall      = !dout_ready;
            isr_clear  = dout_ready;
          end
        end
        OP_MOV: begin
          new_val = apply_bit_op(src_val, mov_op);
          load_x  = src_ok && (op1 == DST_X);
          load_y  = src_ok && (op1 == DST_Y);
        end
        OP_SET: begin
          new_val  = word_t'(op2);
          set_pins = (op1 == DST_PINS);
          load_x   = (op1 == DST_X);
          load_y   = (op1 == DST_Y);
        end
        default: new_val = '0;  // IRQ
      endcase
    end
  end

  // Delay begins once the instruction has completed
  always_ff @(posedge clk) begin
    if (reset) begin
      delay_cnt <= '0;
    end else if (enabled) begin
      if (delaying) begin
        delay_cnt <= delay_cnt - delay_t'(1);
      end else if (!stall) begin
        delay_cnt <= delay;
      end
    end
  end

  a_fifo_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(din_ready && dout_valid))
    else $error("PULL and PUSH handshakes active in the same cycle");

endmodule

// ==== source/program_counter.sv ====
`timescale 1ns/10ps
module program_counter (
  input  logic               clk,
  input  logic               reset,
  input  logic               advance,
  input  logic               jump,
  input  pio_isa_pkg::addr_t target,
  input  pio_isa_pkg::addr_t wrap_top,
  input  pio_isa_pkg::addr_t wrap_target,
  output pio_isa_pkg::addr_t pc
);
  import pio_isa_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (advance) begin
      if (jump) begin
        pc <= target;
      end else if (pc == wrap_top) begin
        pc <= wrap_target;  // Jump has priority over wrap
      end else begin
        pc <= pc + addr_t'(1);
      end
    end
  end

endmodule

// ==== source/scratch_reg.sv ====
`timescale 1ns/10ps
module scratch_reg (
  input  logic               clk,
  input  logic               reset,
  input  logic               load,
  input  logic               dec,
  input  pio_isa_pkg::word_t din,
  output pio_isa_pkg::word_t value
);
  import pio_isa_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
    end else if (load) begin
      value <= din;
    end else if (dec) begin
      value <= value - word_t'(1);  // Zero wraps to all ones
    end
  end

  a_load_dec_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(load && dec))
    else $error("scratch register loaded and decremented together");

endmodule

// ==== source/input_shift_reg.sv ====
`timescale 1ns/10ps
module input_shift_reg (
  input  logic               clk,
  input  logic               reset,
  input  logic               shift,
  input  logic               clear,
  input  pio_isa_pkg::op2_t  count,
  input  pio_isa_pkg::word_t din,
  output pio_isa_pkg::word_t value
);
  import pio_isa_pkg::*;

  logic [5:0]  n;        // Bits to shift in, 1 to 32
  word_t       aligned;  // Low n bits of din moved to the top
  logic [63:0] joined;

  assign n       = (count == '0) ? 6'd32 : {1'b0, count};
  assign aligned = din << (6'd32 - n);
  assign joined  = {value, aligned} << n;

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
    end else if (clear) begin
      value <= '0;  // Word handed to the TX FIFO
    end else if (shift) begin
      value <= joined[63:32];
    end
  end

endmodule

// ==== source/output_shift_reg.sv ====
`timescale 1ns/10ps
module output_shift_reg (
  input  logic               clk,
  input  logic               reset,
  input  logic               shift_dir,
  input  logic               shift,
  input  logic               load,
  input  pio_isa_pkg::op2_t  count,
  input  pio_isa_pkg::word_t din,
  output pio_isa_pkg::word_t value,
  output pio_isa_pkg::word_t shifted_out
);
  import pio_isa_pkg::*;

  logic [5:0] n;     // Bits to shift out, 1 to 32
  logic [5:0] rest;  // Bits that stay behind
  word_t      low_bits;

  assign n    = (count == '0) ? 6'd32 : {1'b0, count};
  assign rest = 6'd32 - n;

  // Low n bits, upper bits cleared
  assign low_bits = (value << rest) >> rest;

  // shift_dir 0 takes from the top, 1 from the bottom
  assign shifted_out = shift_dir ? low_bits : (value >> rest);

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
    end else if (load) begin
      value <= din;
    end else if (shift) begin
      if (shift_dir) begin
        value <= value >> n;
      end else begin
        value <= value << n;  // Full word leaves zero
      end
    end
  end

endmodule

// ==== source/state_machine.sv ====
`timescale 1ns/10ps
module state_machine (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    restart,
  input  logic                    en,
  input  pio_cfg_pkg::clk_div_t   div,
  input  pio_isa_pkg::instr_t     instr,
  input  pio_isa_pkg::word_t      din,
  input  pio_isa_pkg::word_t      input_pins,
  input  pio_isa_pkg::word_t      gpio_pins,
  input  logic                    din_valid,
  input  logic                    dout_ready,
  input  pio_isa_pkg::addr_t      wrap_top,
  input  pio_isa_pkg::addr_t      wrap_target,
  input  pio_cfg_pkg::pin_index_t pins_out_base,
  input  pio_cfg_pkg::pin_index_t pins_set_base,
  input  pio_cfg_pkg::pin_index_t pins_in_base,
  input  pio_cfg_pkg::pin_count_t pins_out_count,
  input  pio_cfg_pkg::pin_count_t pins_set_count,
  input  logic                    shift_dir,
  output pio_isa_pkg::addr_t      pc,
  output logic                    din_ready,
  output logic                    dout_valid,
  output pio_isa_pkg::word_t      dout,
  output pio_isa_pkg::word_t      output_pins
);
  import pio_isa_pkg::*;
  import pio_cfg_pkg::*;

  logic  sm_reset;
  logic  tick;
  logic  advance;
  logic  jump;
  logic  load_x;
  logic  load_y;
  logic  dec_x;
  logic  dec_y;
  logic  isr_shift;
  logic  isr_clear;
  logic  osr_shift;
  logic  osr_load;
  logic  set_pins;
  logic  out_pins;
  op2_t  shift_count;
  word_t new_val;
  word_t reg_din;
  word_t x;
  word_t y;
  word_t isr;
  word_t osr;
  word_t shifted_out;

  // Writes up to five pins starting at base, wrapping past pin 31
  function automatic word_t write_pins(word_t pins, pin_index_t base, pin_count_t count,
                                       word_t val);
    word_t      result;
    pin_index_t idx;
    result = pins;
    for (int i = 0; i < MAX_PINS; i++) begin
      idx = base + pin_index_t'(i);
      if (pin_count_t'(i) < count) begin
        result[idx] = val[i];
      end
    end
    return result;
  endfunction

  assign sm_reset = reset || restart;
  assign dout     = isr;
  assign reg_din  = osr_shift ? shifted_out : new_val;  // OUT X and OUT Y take OSR bits

  always_ff @(posedge clk) begin
    if (sm_reset) begin
      output_pins <= '0;
    end else if (set_pins) begin
      output_pins <= write_pins(output_pins, pins_set_base, pins_set_count, new_val);
    end else if (out_pins) begin
      output_pins <= write_pins(output_pins, pins_out_base, pins_out_count, shifted_out);
    end
  end

  clock_divider clock_divider_inst (.clk(clk), .reset(sm_reset), .div(div), .tick(tick));

  sm_control sm_control_inst (
    .clk(clk), .reset(sm_reset), .en(en), .tick(tick),
    .din_valid(din_valid), .dout_ready(dout_ready), .instr(instr),
    .x(x), .y(y), .isr(isr), .osr(osr), .din(din),
    .input_pins(input_pins), .gpio_pins(gpio_pins), .pins_in_base(pins_in_base),
    .advance(advance), .jump(jump), .load_x(load_x), .load_y(load_y),
    .dec_x(dec_x), .dec_y(dec_y), .isr_shift(isr_shift), .isr_clear(isr_clear),
    .osr_shift(osr_shift), .osr_load(osr_load), .set_pins(set_pins), .out_pins(out_pins),
    .din_ready(din_ready), .dout_valid(dout_valid), .shift_count(shift_count),
    .new_val(new_val)
  );

  program_counter program_counter_inst (
    .clk(clk), .reset(sm_reset), .advance(advance), .jump(jump),
    .target(new_val[4:0]), .wrap_top(wrap_top), .wrap_target(wrap_target), .pc(pc)
  );

  scratch_reg x_reg (
    .clk(clk), .reset(sm_reset), .load(load_x), .dec(dec_x), .din(reg_din), .value(x)
  );

  scratch_reg y_reg (
    .clk(clk), .reset(sm_reset), .load(load_y), .dec(dec_y), .din(reg_din), .value(y)
  );

  input_shift_reg input_shift_reg_inst (
    .clk(clk), .reset(sm_reset), .shift(isr_shift), .clear(isr_clear),
    .count(shift_count), .din(new_val), .value(isr)
  );

  output_shift_reg output_shift_reg_inst (
    .clk(clk), .reset(sm_reset), .shift_dir(shift_dir), .shift(osr_shift),
    .load(osr_load), .count(shift_count), .din(new_val), .value(osr),
    .shifted_out(shifted_out)
  );

endmodule

// ==== verif/tb_state_machine.sv ====
`timescale 1ns/10ps
module tb_state_machine;
  import pio_isa_pkg::*;
  import pio_cfg_pkg::*;

  localparam int CYCLE_LIMIT = 20000;  // Four times the longest test

  logic       clk;
  logic       reset;
  logic       restart;
  logic       en;
  clk_div_t   div;
  instr_t     instr;
  word_t      din;
  word_t      input_pins;
  word_t      gpio_pins;
  logic       din_valid;
  logic       dout_ready;
  addr_t      wrap_top;
  addr_t      wrap_target;
  pin_index_t pins_out_base;
  pin_index_t pins_set_base;
  pin_index_t pins_in_base;
  pin_count_t pins_out_count;
  pin_count_t pins_set_count;
  logic       shift_dir;
  addr_t      pc;
  logic       din_ready;
  logic       dout_valid;
  word_t      dout;
  word_t      output_pins;

  instr_t      prog [32];  // Program store served at pc
  logic [31:0] seed;
  logic [31:0] fifo_state;
  word_t       m_x;
  word_t       m_y;
  word_t       m_isr;
  word_t       m_osr;
  word_t       m_pins;
  addr_t       m_pc;
  word_t       rx_q[$];   // Words accepted by PULL
  word_t       exp_q[$];  // Words the model expects on dout
  logic        model_on;
  logic        stall_mode;
  logic        tx_block;  // Holds the TX FIFO full
  logic        timing_on;
  addr_t       p_pc;
  logic        p_pull;
  logic        p_push;
  word_t       p_din;
  word_t       p_dout;
  word_t       p_pins;
  int          cycles;
  int          since;
  int          last_delay;
  int          pushes;
  int          toggles;

  assign instr = prog[pc];

  state_machine state_machine_inst (.*);

  function automatic logic [31:0] lcg(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int rand_below(int n);
    seed = lcg(seed);
    return int'((seed >> 16) % n);
  endfunction

  function automatic instr_t enc(opcode_e op, int d, op1_t a, int b);
    return {op, delay_t'(d), a, op2_t'(b)};
  endfunction

  task automatic fail_now(string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_eq(word_t got, word_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      fail_now("value check failed");
    end
  endtask

  function automatic word_t mask_n(int n);
    return (n >= 32) ? '1 : word_t'((64'd1 << n) - 64'd1);
  endfunction

  function automatic word_t put_pins(word_t pins, pin_index_t base, pin_count_t count,
                                     word_t val);
    word_t r;
    r = pins;
    for (int i = 0; i < int'(count); i++) begin
      r[(int'(base) + i) % 32] = val[i];  // Pin numbers wrap
    end
    return r;
  endfunction

  function automatic word_t pick_src(op1_t code);
    word_t rot;
    for (int i = 0; i < 32; i++) begin
      rot[i] = input_pins[(i + int'(pins_in_base)) % 32];  // Pin at the IN base lands on bit 0
    end
    case (code)
      SRC_PINS: return rot;
      SRC_X:    return m_x;
      SRC_Y:    return m_y;
      SRC_ISR:  return m_isr;
      SRC_OSR:  return m_osr;
      default:  return '0;
    endcase
  endfunction

  // Executes one instruction of the reference model
  task automatic model_step(addr_t at);
    instr_t ins;
    op1_t   a;
    op2_t   b;
    int     n;
    word_t  v;
    word_t  outv;
    logic   jmp;
    ins = prog[at];
    a = ins[7:5];
    b = ins[4:0];
    n = (b == '0) ? 32 : int'(b);
    jmp = 1'b0;
    case (ins[15:13])
      3'd0: begin
        case (a)
          3'd0: jmp = 1'b1;
          3'd1: jmp = (m_x == '0);
          3'd2: begin
            jmp = (m_x != '0);
            m_x = m_x - 32'd1;
          end
          3'd3: jmp = (m_y == '0);
          3'd4: begin
            jmp = (m_y != '0);
            m_y = m_y - 32'd1;
          end
          3'd5: jmp = (m_x != m_y);
          default: jmp = 1'b0;
        endcase
      end
      3'd2: if (a <= 3'd3) m_isr = word_t'(64'(m_isr) << n) | (pick_src(a) & mask_n(n));
      3'd3: begin
        if (a <= 3'd3) begin
          if (shift_dir) begin
            outv = m_osr & mask_n(n);
            m_osr = word_t'(64'(m_osr) >> n);
          end else begin
            outv = word_t'((64'(m_osr) << n) >> 32);
            m_osr = word_t'(64'(m_osr) << n);
          end
          if (a == 3'd0) m_pins = put_pins(m_pins, pins_out_base, pins_out_count, outv);
          if (a == 3'd1) m_x = outv;
          if (a == 3'd2) m_y = outv;
        end
      end
      3'd4: begin
        if (a[2]) begin
          if (rx_q.size() == 0) fail_now("PULL finished but no RX word was handed over");
          m_osr = rx_q.pop_front();
        end else begin
          exp_q.push_back(m_isr);
          m_isr = '0;
        end
      end
      3'd5: begin
        if (b[2:0] != 3'd4 && b[2:0] != 3'd5) begin
          v = pick_src(b[2:0]);
          if (b[4:3] == 2'd1) v = ~v;
          if (b[4:3] == 2'd2) v = {<<{v}};  // Bit reverse
          if (a == 3'd1) m_x = v;
          if (a == 3'd2) m_y = v;
        end
      end
      3'd7: begin
        if (a == 3'd0) m_pins = put_pins(m_pins, pins_set_base, pins_set_count, word_t'(b));
        if (a == 3'd1) m_x = word_t'(b);
        if (a == 3'd2) m_y = word_t'(b);
      end
      default: ;  // WAIT and IRQ change no state
    endcase
    m_pc = jmp ? addr_t'(b) : ((at == wrap_top) ? wrap_target : at + 5'd1);
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Monitor samples at the falling edge, where DUT outputs are settled
  always @(negedge clk) begin
    cycles++;
    since++;
    if (cycles >= CYCLE_LIMIT) fail_now("timeout, the run went past its cycle limit");
    if (model_on) begin
      if (p_pull) rx_q.push_back(p_din);
      if (pc != p_pc) begin
        if (timing_on && last_delay >= 0) begin
          check_eq(word_t'(since), word_t'(int'(div) * (1 + last_delay)), "pc spacing");
        end
        last_delay = int'(prog[p_pc][12:8]);
        since = 0;
        model_step(p_pc);
        check_eq(word_t'(pc), word_t'(m_pc), "pc");
        check_eq(output_pins, m_pins, "output pins");
      end
      if (p_push) begin
        if (exp_q.size() == 0) fail_now("a word was pushed that the model did not expect");
        check_eq(p_dout, exp_q.pop_front(), "pushed word");
        pushes++;
      end
      if (output_pins[pins_set_base] && !p_pins[pins_set_base]) toggles++;
    end
    p_pc   = pc;
    p_pull = din_valid && din_ready;
    p_push = dout_valid && dout_ready;
    p_din  = din;
    p_dout = dout;
    p_pins = output_pins;
  end

  // FIFO partner side, random stalls come from a separate stream
  always @(posedge clk) begin
    #1;
    fifo_state = lcg(fifo_state);
    din_valid  = stall_mode ? (fifo_state[21:20] != 2'd0) : 1'b1;
    dout_ready = tx_block ? 1'b0 : (stall_mode ? (fifo_state[19:18] != 2'd0) : 1'b1);
    din        = fifo_state ^ (fifo_state >> 13);
  end

  task automatic defaults();
    wrap_top    = 5'd31;
    wrap_target = 5'd0;
    div         = 16'd1;
    stall_mode  = 1'b0;
    tx_block    = 1'b0;
    timing_on   = 1'b0;
    shift_dir   = 1'b0;
    for (int i = 0; i < 32; i++) begin
      prog[i] = enc(OP_SET, 0, DST_NULL, 0);  // No-op filler
    end
  endtask

  task automatic begin_run();
    @(posedge clk);
    #1;
    restart = 1'b1;
    @(posedge clk);
    #1;
    restart = 1'b0;
    m_x = '0;
    m_y = '0;
    m_isr = '0;
    m_osr = '0;
    m_pins = '0;
    m_pc = '0;
    rx_q.delete();
    exp_q.delete();
    pushes = 0;
    toggles = 0;
    since = 0;
    last_delay = -1;
    p_pc = '0;  // Restart has just cleared pc
    model_on = 1'b1;
    en = 1'b1;
  endtask

  task automatic stop_run();
    @(posedge clk);
    #1;
    en = 1'b0;
    @(negedge clk);
    #1;
    model_on = 1'b0;
  endtask

  task automatic run_to(addr_t end_pc);
    do @(negedge clk); while (pc != end_pc);
    stop_run();
  endtask

  task automatic loop_test();
    int v;
    defaults();
    v = rand_below(12);
    pins_set_base  = pin_index_t'(rand_below(32));
    pins_set_count = 3'd1;
    prog[0] = enc(OP_SET, 0, DST_X, v);
    prog[1] = enc(OP_SET, 0, DST_PINS, 1);
    prog[2] = enc(OP_SET, 0, DST_PINS, 0);
    prog[3] = enc(OP_JMP, 0, COND_X_DEC, 1);
    begin_run();
    run_to(5'd5);
    check_eq(word_t'(toggles), word_t'(v + 1), "toggle count");
    check_eq(output_pins, m_pins, "final pins");
  endtask

  task automatic fifo_test();
    defaults();
    stall_mode = 1'b1;
    shift_dir  = 1'(rand_below(2));
    prog[0] = enc(OP_PUSH_PULL, 0, 3'b100, 0);
    for (int k = 0; k < 4; k++) begin
      prog[1 + 3 * k] = enc(OP_OUT, 0, DST_X, 8);
      prog[2 + 3 * k] = enc(OP_MOV, 0, DST_Y, int'({2'(rand_below(4)), SRC_X}));
      prog[3 + 3 * k] = enc(OP_IN, 0, SRC_Y, 8);
    end
    prog[13] = enc(OP_PUSH_PULL, 0, 3'b000, 0);
    begin_run();
    run_to(5'd14);
    check_eq(word_t'(pushes), 32'd1, "push count");
    check_eq(word_t'(exp_q.size()), 32'd0, "words left in the model");
    check_eq(word_t'(rx_q.size()), 32'd0, "RX words taken outside PULL");
  endtask

  task automatic pins_test();
    defaults();
    pins_out_base  = pin_index_t'(rand_below(32));
    pins_set_base  = pin_index_t'(rand_below(32));
    pins_out_count = pin_count_t'(rand_below(6));
    pins_set_count = pin_count_t'(rand_below(6));
    shift_dir      = 1'(rand_below(2));
    prog[0] = enc(OP_PUSH_PULL, 0, 3'b100, 0);
    prog[1] = enc(OP_OUT, 0, DST_PINS, rand_below(32));
    prog[2] = enc(OP_SET, 0, DST_PINS, rand_below(32));
    prog[3] = enc(OP_OUT, 0, DST_PINS, rand_below(32));
    prog[4] = enc(OP_SET, 0, DST_PINS, rand_below(32));
    prog[5] = enc(OP_OUT, 0, DST_PINS, rand_below(32));
    begin_run();
    run_to(5'd7);
  endtask

  task automatic wrap_test();
    int wt;
    defaults();
    wt = 2 + rand_below(3);
    wrap_target = addr_t'(wt);
    wrap_top    = addr_t'(wt + 5);
    prog[0]      = enc(OP_SET, 0, DST_X, rand_below(4));
    prog[1]      = enc(OP_SET, 0, DST_Y, rand_below(4));
    prog[wt]     = enc(OP_JMP, 0, COND_Y_ZERO, wt + 3);
    prog[wt + 1] = enc(OP_JMP, 0, COND_X_NE_Y, wt + 4);
    prog[wt + 2] = enc(OP_SET, 0, DST_X, 1);
    prog[wt + 3] = enc(OP_JMP, 0, COND_Y_DEC, wt + 5);
    prog[wt + 4] = enc(OP_SET, 0, DST_Y, 2);
    prog[wt + 5] = enc(OP_MOV, 0, DST_X, int'({2'(rand_below(3)), SRC_Y}));
    begin_run();
    repeat (60) @(posedge clk);
    stop_run();
  endtask

  task automatic timing_test();
    defaults();
    div = clk_div_t'(1 + rand_below(7));
    for (int i = 0; i < 32; i++) begin
      prog[i] = enc(OP_SET, rand_below(4), DST_NULL, 0);
    end
    timing_on = 1'b1;
    begin_run();
    repeat (300) @(posedge clk);
    stop_run();
  endtask

  task automatic wait_restart_test();
    int   p;
    logic pol;
    defaults();
    p   = rand_below(32);
    pol = 1'(rand_below(2));
    gpio_pins      = word_t'(rand_below(65536));
    gpio_pins[p]   = ~pol;
    pins_set_base  = 5'd0;
    pins_set_count = 3'd1;
    tx_block       = 1'b1;
    prog[0] = enc(OP_WAIT, 0, {pol, 2'b00}, p);
    prog[1] = enc(OP_SET, 0, DST_PINS, 1);
    prog[3] = enc(OP_PUSH_PULL, 0, 3'b000, 0);  // Stays blocked on the full TX FIFO
    begin_run();
    repeat (30) @(posedge clk);
    #1;
    check_eq(word_t'(pc), 32'd0, "pc held by WAIT");
    gpio_pins[p] = pol;
    do @(negedge clk); while (pc != 5'd3);
    check_eq(output_pins, 32'd1, "pins before restart");
    check_eq(word_t'(dout_valid), 32'd1, "dout_valid of a blocked PUSH");
    @(posedge clk);
    #1;
    model_on = 1'b0;
    restart  = 1'b1;
    @(posedge clk);
    #1;
    restart = 1'b0;
    @(negedge clk);
    check_eq(word_t'(pc), 32'd0, "pc after restart");
    check_eq(output_pins, 32'd0, "pins after restart");
    check_eq(word_t'(dout_valid), 32'd0, "dout_valid after restart");
  endtask

  initial begin
    seed           = 32'd10697;
    fifo_state     = lcg(32'd10697);
    reset          = 1'b1;
    restart        = 1'b0;
    en             = 1'b0;
    din            = '0;
    input_pins     = 32'h5a3c_96e1;
    gpio_pins      = '0;
    din_valid      = 1'b0;
    dout_ready     = 1'b0;
    pins_out_base  = '0;
    pins_set_base  = '0;
    pins_in_base   = 5'd3;
    pins_out_count = '0;
    pins_set_count = '0;
    model_on       = 1'b0;
    cycles         = 0;
    defaults();
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (3) loop_test();
    repeat (3) fifo_test();
    repeat (4) pins_test();
    repeat (2) wrap_test();
    repeat (2) timing_test();
    wait_restart_test();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
source/pio_isa_pkg.sv
source/pio_cfg_pkg.sv
source/clock_divider.sv
source/sm_control.sv
source/program_counter.sv
source/scratch_reg.sv
source/input_shift_reg.sv
source/output_shift_reg.sv
source/state_machine.sv
verif/tb_state_machine.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_state_machine
RTL_TOP   ?= state_machine
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
